// File: source/taint_pkg.sv
`default_nettype none

package taint_pkg;

    // default operand and result width
    parameter int DATA_WIDTH = 16;

    // bit 2 marks the shift class
    // 3'b111 is unused and its low bits match OP_XOR
    typedef enum logic [2:0] {
        OP_AND  = 3'b000,
        OP_OR   = 3'b001,
        OP_XOR  = 3'b011,
        OP_MUX  = 3'b010,
        OP_SHL  = 3'b100,
        OP_SHR  = 3'b101,
        OP_SSHR = 3'b110
    } taint_op_e;

    // true for the three shift codes only
    // the unused code stays with the logic unit
    function automatic logic op_is_shift(input taint_op_e op);
        return op[2] & ~(op[1] & op[0]);
    endfunction

endpackage

`default_nettype wire

// File: source/operand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface operand_if
    import taint_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH
);

    taint_op_e        op;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] a_taint;
    logic [WIDTH-1:0] b_taint;

    // driven from the top level ports
    modport source (output op, a, b, a_taint, b_taint);

    // read by the logic and shift units
    modport unit (input op, a, b, a_taint, b_taint);

endinterface

`default_nettype wire

// File: source/logic_taint_unit.sv
`timescale 1ns/1ps
`default_nettype none

module logic_taint_unit
    import taint_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH
) (
    operand_if.unit          ops,
    input  logic             sel,
    input  logic             sel_taint,
    output logic [WIDTH-1:0] data,
    output logic [WIDTH-1:0] taint
);

    taint_op_e        low_op;
    logic [WIDTH-1:0] both_taint;
    logic [WIDTH-1:0] and_taint;
    logic [WIDTH-1:0] or_taint;
    logic [WIDTH-1:0] mux_taint;
    logic             any_taint;

    // only the low two bits matter here
    // so the unused code decodes as xor
    assign low_op = taint_op_e'({1'b0, ops.op[1:0]});

    assign both_taint = ops.a_taint & ops.b_taint;

    // a tainted bit only matters when the other side is non-controlling
    assign and_taint = (ops.a_taint & ops.b) | (ops.b_taint & ops.a) | both_taint;

    // same idea with the controlling value flipped
    assign or_taint = (ops.a_taint & ~ops.b) | (ops.b_taint & ~ops.a) | both_taint;

    assign any_taint = |{ops.a_taint, ops.b_taint};

    // a tainted select may pick either side, so differing bits are suspect
    always_comb begin
        mux_taint = sel ? ops.b_taint : ops.a_taint;
        if (sel_taint) begin
            mux_taint = mux_taint | (ops.a ^ ops.b);
        end
    end

    always_comb begin
        case (low_op)
            OP_AND: begin
                data  = ops.a & ops.b;
                taint = and_taint;
            end
            OP_OR: begin
                data  = ops.a | ops.b;
                taint = or_taint;
            end
            OP_MUX: begin
                data  = sel ? ops.b : ops.a;
                taint = mux_taint;
            end
            default: begin
                // xor smears any input taint over the word
                data  = ops.a ^ ops.b;
                taint = {WIDTH{any_taint}};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/shift_taint_unit.sv
`timescale 1ns/1ps
`default_nettype none

module shift_taint_unit
    import taint_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH
) (
    operand_if.unit          ops,
    output logic [WIDTH-1:0] data,
    output logic [WIDTH-1:0] taint
);

    logic             amount_tainted;
    logic [WIDTH-1:0] shl_data;
    logic [WIDTH-1:0] shr_data;
    logic [WIDTH-1:0] sshr_data;
    logic [WIDTH-1:0] shl_taint;
    logic [WIDTH-1:0] shr_taint;
    logic [WIDTH-1:0] sshr_taint;

    // full unsigned b as amount, overshift empties or sign-fills
    assign shl_data  = ops.a << ops.b;
    assign shr_data  = ops.a >> ops.b;
    assign sshr_data = $signed(ops.a) >>> ops.b;

    // taint follows the data in the same direction
    assign shl_taint  = ops.a_taint << ops.b;
    assign shr_taint  = ops.a_taint >> ops.b;
    assign sshr_taint = $signed(ops.a_taint) >>> ops.b;

    // an uncertain amount could move any bit anywhere
    assign amount_tainted = |ops.b_taint;

    always_comb begin
        case (ops.op)
            OP_SHR: begin
                data  = shr_data;
                taint = shr_taint;
            end
            OP_SSHR: begin
                data  = sshr_data;
                taint = sshr_taint;
            end
            default: begin
                data  = shl_data;
                taint = shl_taint;
            end
        endcase
        if (amount_tainted) begin
            taint = {WIDTH{1'b1}};
        end
    end

endmodule

`default_nettype wire

// File: source/taint_shadow_reg.sv
`timescale 1ns/1ps
`default_nettype none

module taint_shadow_reg
    import taint_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH
) (
    input  logic             pos_clk,
    input  logic             pos_arst,
    input  taint_op_e        op,
    input  logic [WIDTH-1:0] logic_data,
    input  logic [WIDTH-1:0] logic_taint,
    input  logic [WIDTH-1:0] shift_data,
    input  logic [WIDTH-1:0] shift_taint,
    input  logic             en,
    input  logic             en_taint,
    input  logic             srst,
    input  logic             srst_taint,
    output logic [WIDTH-1:0] q,
    output logic [WIDTH-1:0] q_taint
);

    logic             use_shift;
    logic [WIDTH-1:0] d;
    logic [WIDTH-1:0] d_taint;
    logic [WIDTH-1:0] load_diff;
    logic [WIDTH-1:0] en_flip;
    logic [WIDTH-1:0] clear_taint;

    // pick the unit that owns this op
    assign use_shift = op_is_shift(op);

    always_comb begin
        if (use_shift) begin
            d       = shift_data;
            d_taint = shift_taint;
        end else begin
            d       = logic_data;
            d_taint = logic_taint;
        end
    end

    // bits that would change if the enable went the other way
    assign load_diff = d ^ q;
    assign en_flip   = en_taint ? load_diff : '0;

    // clear value is zero, so a tainted clear exposes d itself
    assign clear_taint = srst_taint ? d : '0;

    // data register, clear beats enable
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            q <= '0;
        end else if (srst) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

    // shadow register tracks the same priority
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            q_taint <= '0;
        end else if (srst) begin
            q_taint <= clear_taint;
        end else if (en) begin
            q_taint <= d_taint | en_flip;
        end else begin
            // holding, but a tainted enable may have loaded
            q_taint <= q_taint | en_flip;
        end
    end

endmodule

`default_nettype wire

// File: source/taint_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module taint_alu_top
    import taint_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH
) (
    input  logic             pos_clk,
    input  logic             pos_arst,
    input  taint_op_e        op,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic [WIDTH-1:0] a_taint,
    input  logic [WIDTH-1:0] b_taint,
    input  logic             sel,
    input  logic             sel_taint,
    input  logic             en,
    input  logic             en_taint,
    input  logic             srst,
    input  logic             srst_taint,
    output logic [WIDTH-1:0] q,
    output logic [WIDTH-1:0] q_taint
);

    logic [WIDTH-1:0] logic_data;
    logic [WIDTH-1:0] logic_taint;
    logic [WIDTH-1:0] shift_data;
    logic [WIDTH-1:0] shift_taint;

    operand_if #(.WIDTH(WIDTH)) ops0 ();

    // operand bundle for both units
    assign ops0.op      = op;
    assign ops0.a       = a;
    assign ops0.b       = b;
    assign ops0.a_taint = a_taint;
    assign ops0.b_taint = b_taint;

    logic_taint_unit #(.WIDTH(WIDTH)) logic0 (
        .ops       (ops0.unit),
        .sel       (sel),
        .sel_taint (sel_taint),
        .data      (logic_data),
        .taint     (logic_taint)
    );

    shift_taint_unit #(.WIDTH(WIDTH)) shift0 (
        .ops   (ops0.unit),
        .data  (shift_data),
        .taint (shift_taint)
    );

    // one cycle from operands to q
    taint_shadow_reg #(.WIDTH(WIDTH)) shadow0 (
        .pos_clk     (pos_clk),
        .pos_arst    (pos_arst),
        .op          (op),
        .logic_data  (logic_data),
        .logic_taint (logic_taint),
        .shift_data  (shift_data),
        .shift_taint (shift_taint),
        .en          (en),
        .en_taint    (en_taint),
        .srst        (srst),
        .srst_taint  (srst_taint),
        .q           (q),
        .q_taint     (q_taint)
    );

endmodule

`default_nettype wire

// File: testbench/taint_alu_props.sv
`timescale 1ns/1ps
`default_nettype none

module taint_alu_props
    import taint_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH
) (
    input logic             pos_clk,
    input logic             pos_arst,
    input logic [WIDTH-1:0] logic_taint,
    input logic [WIDTH-1:0] shift_taint,
    input logic             en_taint,
    input logic             srst,
    input logic             srst_taint,
    input logic [WIDTH-1:0] q,
    input logic [WIDTH-1:0] q_taint
);

    // shadow stays clean through a held reset
    reset_clears_taint: assert property (
        @(posedge pos_clk) (pos_arst && $past(pos_arst)) |-> q_taint == '0
    ) else $error("q_taint is not zero while reset is held");

    // untainted clear leaves nothing behind
    clear_zeros_both: assert property (
        @(posedge pos_clk) disable iff (pos_arst)
        (srst && !srst_taint) |=> (q == '0 && q_taint == '0)
    ) else $error("q or q_taint not zero after a clean clear");

    // no taint source means no taint appears
    clean_stays_clean: assert property (
        @(posedge pos_clk) disable iff (pos_arst)
        (logic_taint == '0 && shift_taint == '0 && !en_taint && !srst_taint
            && q_taint == '0) |=> q_taint == '0
    ) else $error("q_taint became set without any taint source");

endmodule

bind taint_shadow_reg taint_alu_props #(.WIDTH(WIDTH)) props0 (
    .pos_clk     (pos_clk),
    .pos_arst    (pos_arst),
    .logic_taint (logic_taint),
    .shift_taint (shift_taint),
    .en_taint    (en_taint),
    .srst        (srst),
    .srst_taint  (srst_taint),
    .q           (q),
    .q_taint     (q_taint)
);

`default_nettype wire

// File: testbench/taint_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module taint_alu_tb
    import taint_pkg::*;
();

    localparam int WIDTH         = 16;
    localparam int NUM_ROWS      = 28;
    localparam int RESET_TIMEOUT = 20;

    // ctrl is {sel, sel_taint, en, en_taint, srst, srst_taint}
    typedef struct packed {
        taint_op_e        op;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] at;
        logic [WIDTH-1:0] bt;
        logic [5:0]       ctrl;
        logic [WIDTH-1:0] exp_q;
        logic [WIDTH-1:0] exp_qt;
    } row_t;

    logic             pos_clk;
    logic             pos_arst;
    taint_op_e        op;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] a_taint;
    logic [WIDTH-1:0] b_taint;
    logic             sel;
    logic             sel_taint;
    logic             en;
    logic             en_taint;
    logic             srst;
    logic             srst_taint;
    logic [WIDTH-1:0] q;
    logic [WIDTH-1:0] q_taint;

    row_t rows [NUM_ROWS];
    int   row_count  = 0;
    int   pass_count = 0;
    int   fail_count = 0;

    taint_alu_top #(.WIDTH(WIDTH)) dut0 (
        .pos_clk    (pos_clk),
        .pos_arst   (pos_arst),
        .op         (op),
        .a          (a),
        .b          (b),
        .a_taint    (a_taint),
        .b_taint    (b_taint),
        .sel        (sel),
        .sel_taint  (sel_taint),
        .en         (en),
        .en_taint   (en_taint),
        .srst       (srst),
        .srst_taint (srst_taint),
        .q          (q),
        .q_taint    (q_taint)
    );

    initial begin
        pos_clk = 1'b0;
        forever #5 pos_clk = ~pos_clk;
    end

    // reference model, returns {q, q_taint} after one edge
    function automatic logic [2*WIDTH-1:0] model_step(input row_t r,
                                                      input logic [WIDTH-1:0] pq,
                                                      input logic [WIDTH-1:0] pqt);
        logic [WIDTH-1:0] d;
        logic [WIDTH-1:0] dt;
        logic [WIDTH-1:0] flip;
        int               amt;
        d   = '0;
        dt  = '0;
        amt = {16'd0, r.b};
        case (r.op)
            OP_AND: begin
                d  = r.a & r.b;
                dt = (r.at & r.b) | (r.bt & r.a) | (r.at & r.bt);
            end
            OP_OR: begin
                d  = r.a | r.b;
                dt = (r.at & ~r.b) | (r.bt & ~r.a) | (r.at & r.bt);
            end
            OP_MUX: begin
                d  = r.ctrl[5] ? r.b : r.a;
                dt = r.ctrl[5] ? r.bt : r.at;
                if (r.ctrl[4]) begin
                    dt = dt | (r.a ^ r.b);
                end
            end
            OP_SHL, OP_SHR, OP_SSHR: begin
                d  = r.a;
                dt = r.at;
                // one position per step, sixteen steps empty the word
                for (int k = 0; k < WIDTH; k++) begin
                    if (k < amt && r.op == OP_SHL) begin
                        d  = {d[WIDTH-2:0], 1'b0};
                        dt = {dt[WIDTH-2:0], 1'b0};
                    end else if (k < amt && r.op == OP_SHR) begin
                        d  = {1'b0, d[WIDTH-1:1]};
                        dt = {1'b0, dt[WIDTH-1:1]};
                    end else if (k < amt) begin
                        d  = {d[WIDTH-1], d[WIDTH-1:1]};
                        dt = {dt[WIDTH-1], dt[WIDTH-1:1]};
                    end
                end
                if (r.bt != '0) begin
                    dt = '1;
                end
            end
            default: begin
                d  = r.a ^ r.b;
                dt = (|{r.at, r.bt}) ? '1 : '0;
            end
        endcase
        flip = r.ctrl[2] ? (d ^ pq) : '0;
        if (r.ctrl[1]) begin
            return {{WIDTH{1'b0}}, (r.ctrl[0] ? d : {WIDTH{1'b0}})};
        end else if (r.ctrl[3]) begin
            return {d, dt | flip};
        end
        return {pq, pqt | flip};
    endfunction

    task automatic add_row(input taint_op_e row_op, input logic [WIDTH-1:0] ra,
                           input logic [WIDTH-1:0] rb, input logic [WIDTH-1:0] rat,
                           input logic [WIDTH-1:0] rbt, input logic [5:0] ctrl,
                           input logic [WIDTH-1:0] eq, input logic [WIDTH-1:0] eqt);
        rows[row_count] = '{row_op, ra, rb, rat, rbt, ctrl, eq, eqt};
        row_count++;
    endtask

    task automatic add_random_row();
        row_t             r;
        logic [2:0]       code;
        logic [2*WIDTH-1:0] res;
        code = 3'($urandom_range(0, 7));
        r.op = taint_op_e'(code);
        r.a  = 16'($urandom);
        // keep shift amounts near the word size
        r.b  = code[2] ? 16'($urandom_range(0, 19)) : 16'($urandom);
        r.at = 16'($urandom & $urandom);
        r.bt = ($urandom_range(0, 2) == 0) ? 16'($urandom & $urandom) : 16'h0000;
        r.ctrl    = 6'($urandom);
        r.ctrl[1] = ($urandom_range(0, 3) == 0);
        res = model_step(r, rows[row_count-1].exp_q, rows[row_count-1].exp_qt);
        r.exp_q  = res[2*WIDTH-1:WIDTH];
        r.exp_qt = res[WIDTH-1:0];
        rows[row_count] = r;
        row_count++;
    endtask

    task automatic build_table();
        // logic ops
        add_row(OP_AND, 16'hFF00, 16'h0F0F, 16'h00FF, 16'h0000, 6'b00_10_00, 16'h0F00, 16'h000F);
        add_row(OP_AND, 16'h3C3C, 16'h5A5A, 16'h00F0, 16'h0F00, 6'b00_10_00, 16'h1818, 16'h0C50);
        add_row(OP_AND, 16'h0000, 16'h0000, 16'h000F, 16'h00FF, 6'b00_10_00, 16'h0000, 16'h000F);
        add_row(OP_OR, 16'h00FF, 16'hF00F, 16'h0F0F, 16'h0000, 6'b00_10_00, 16'hF0FF, 16'h0F00);
        add_row(OP_OR, 16'h1234, 16'h0000, 16'h0000, 16'hFF00, 6'b00_10_00, 16'h1234, 16'hED00);
        add_row(OP_XOR, 16'hAAAA, 16'h5555, 16'h0000, 16'h0000, 6'b00_10_00, 16'hFFFF, 16'h0000);
        add_row(OP_XOR, 16'h1234, 16'h4321, 16'h0001, 16'h0000, 6'b00_10_00, 16'h5115, 16'hFFFF);
        add_row(taint_op_e'(3'b111), 16'hF0F0, 16'h0FF0, 16'h0000, 16'h8000, 6'b00_10_00,
                16'hFF00, 16'hFFFF);
        add_row(OP_MUX, 16'hABCD, 16'h1234, 16'h00F0, 16'hFF00, 6'b00_10_00, 16'hABCD, 16'h00F0);
        add_row(OP_MUX, 16'hFF00, 16'hF0F0, 16'h0000, 16'h0001, 6'b11_10_00, 16'hF0F0, 16'h0FF1);
        // shifts, including overshift
        add_row(OP_SHL, 16'h00F3, 16'h0004, 16'h0011, 16'h0000, 6'b00_10_00, 16'h0F30, 16'h0110);
        add_row(OP_SHR, 16'hF000, 16'h0008, 16'h8100, 16'h0000, 6'b00_10_00, 16'h00F0, 16'h0081);
        add_row(OP_SSHR, 16'h8400, 16'h0004, 16'h8000, 16'h0000, 6'b00_10_00, 16'hF840, 16'hF800);
        add_row(OP_SHL, 16'h0001, 16'h0001, 16'h0000, 16'h0001, 6'b00_10_00, 16'h0002, 16'hFFFF);
        add_row(OP_SSHR, 16'h8001, 16'h0014, 16'h8000, 16'h0000, 6'b00_10_00, 16'hFFFF, 16'hFFFF);
        add_row(OP_SHR, 16'hFFFF, 16'h0010, 16'hFFFF, 16'h0000, 6'b00_10_00, 16'h0000, 16'h0000);
        // load, hold, tainted enable on hold and on load
        add_row(OP_AND, 16'h00FF, 16'h0FFF, 16'h0000, 16'h0000, 6'b00_10_00, 16'h00FF, 16'h0000);
        add_row(OP_XOR, 16'hFFFF, 16'h0000, 16'h0000, 16'h0000, 6'b00_00_00, 16'h00FF, 16'h0000);
        add_row(OP_XOR, 16'h0F0F, 16'h0000, 16'h0000, 16'h0000, 6'b00_01_00, 16'h00FF, 16'h0FF0);
        add_row(OP_OR, 16'h1100, 16'h0011, 16'h0000, 16'h0000, 6'b00_11_00, 16'h1111, 16'h11EE);
        // clear beats enable, then a tainted clear
        add_row(OP_AND, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'h0000, 6'b00_10_10, 16'h0000, 16'h0000);
        add_row(OP_XOR, 16'h00AA, 16'h0000, 16'h0000, 16'h0000, 6'b00_10_00, 16'h00AA, 16'h0000);
        add_row(OP_SHL, 16'h0123, 16'h0004, 16'h0000, 16'h0000, 6'b00_00_11, 16'h0000, 16'h1230);
        for (int i = 0; i < 4; i++) begin
            add_random_row();
        end
        // leaves q non-zero for the async reset check
        add_row(OP_MUX, 16'hBEEF, 16'h0000, 16'h0F00, 16'h0000, 6'b00_10_00, 16'hBEEF, 16'h0F00);
    endtask

    task automatic apply_row(input row_t r);
        op         <= r.op;
        a          <= r.a;
        b          <= r.b;
        a_taint    <= r.at;
        b_taint    <= r.bt;
        sel        <= r.ctrl[5];
        sel_taint  <= r.ctrl[4];
        en         <= r.ctrl[3];
        en_taint   <= r.ctrl[2];
        srst       <= r.ctrl[1];
        srst_taint <= r.ctrl[0];
    endtask

    task automatic drive_idle();
        en         <= 1'b0;
        en_taint   <= 1'b0;
        srst       <= 1'b0;
        srst_taint <= 1'b0;
    endtask

    task automatic check_row(input int idx);
        logic row_ok;
        row_ok = 1'b1;
        assert (q === rows[idx].exp_q) else begin
            $display("MISMATCH at %0t: row %0d q is %h, expected %h",
                     $time, idx, q, rows[idx].exp_q);
            row_ok = 1'b0;
        end
        assert (q_taint === rows[idx].exp_qt) else begin
            $display("MISMATCH at %0t: row %0d q_taint is %h, expected %h",
                     $time, idx, q_taint, rows[idx].exp_qt);
            row_ok = 1'b0;
        end
        $display("row %0d op %b: %s", idx, rows[idx].op, row_ok ? "ok" : "FAILED");
        if (row_ok) pass_count++;
        else fail_count++;
    endtask

    task automatic check_cleared(input string what);
        logic ok;
        ok = 1'b1;
        assert (q === '0 && q_taint === '0) else begin
            $display("MISMATCH at %0t: %s left q %h, q_taint %h", $time, what, q, q_taint);
            ok = 1'b0;
        end
        $display("%s: %s", what, ok ? "ok" : "FAILED");
        if (ok) pass_count++;
        else fail_count++;
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        while (pos_arst !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge pos_clk);
            cycles++;
        end
        released = (pos_arst === 1'b0);
    endtask

    task automatic run_table();
        @(negedge pos_clk);
        check_cleared("reset release");
        // row i is checked half a cycle after the edge that loads it
        for (int i = 0; i < row_count; i++) begin
            @(posedge pos_clk);
            apply_row(rows[i]);
            if (i > 0) begin
                @(negedge pos_clk);
                check_row(i - 1);
            end
        end
        @(posedge pos_clk);
        drive_idle();
        @(negedge pos_clk);
        check_row(row_count - 1);
        // raised after the edge, so only the async path can clear
        @(posedge pos_clk);
        pos_arst <= 1'b1;
        @(negedge pos_clk);
        check_cleared("async reset");
    endtask

    task automatic finish_run();
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        logic released;
        pos_arst   = 1'b1;
        op         = OP_AND;
        a          = '0;
        b          = '0;
        a_taint    = '0;
        b_taint    = '0;
        sel        = 1'b0;
        sel_taint  = 1'b0;
        en         = 1'b0;
        en_taint   = 1'b0;
        srst       = 1'b0;
        srst_taint = 1'b0;
        void'($urandom(56955));
        build_table();
        repeat (4) @(posedge pos_clk);
        pos_arst <= 1'b0;
        wait_reset_release(released);
        if (!released) begin
            $display("timeout: reset was never released");
            fail_count++;
        end else begin
            run_table();
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: build.f
source/taint_pkg.sv
source/operand_if.sv
source/logic_taint_unit.sv
source/shift_taint_unit.sv
source/taint_shadow_reg.sv
source/taint_alu_top.sv
testbench/taint_alu_props.sv
testbench/taint_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module taint_alu_tb -f build.f \
    && ./obj_dir/Vtaint_alu_tb | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
